/* alu_slave.sv */
`timescale 1ns/100ps

module alu_slave import exu_pkg::*; (
    input  alu_op_e         op,
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    output logic [XLEN-1:0] y,
    output logic            overflow
);

    logic [SHAMT_W-1:0] shamt;

    assign shamt = a[SHAMT_W-1:0];

    always_comb begin
        y        = '0;
        overflow = 1'b0;
        case (op)
            ADD: begin
                y        = a + b;
                overflow = (a[XLEN-1] == b[XLEN-1]) & (y[XLEN-1] != a[XLEN-1]);
            end
            ADDU: begin
                y = a + b;
            end
            SUB: begin
                y        = a - b;
                overflow = (a[XLEN-1] ^ b[XLEN-1]) & (y[XLEN-1] == b[XLEN-1]);
            end
            SUBU: begin
                y = a - b;
            end

            SLT,
            SLTI: begin
                y = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            end
            SLTU,
            SLTIU: begin
                y = {{(XLEN-1){1'b0}}, a < b};
            end

            AND: y = a & b;
            OR:  y = a | b;
            NOR: y = ~(a | b);
            XOR: y = a ^ b;
            LUI: y = {b[XLEN/2-1:0], {(XLEN/2){1'b0}}};

            // b is the shifted value, a supplies the amount
            SLL,
            SLLV: begin
                y = b << shamt;
            end
            SRL,
            SRLV: begin
                y = b >> shamt;
            end
            SRA,
            SRAV: begin
                y = $signed(b) >>> shamt;
            end
            ROTR: begin
                y = (b >> shamt) | (b << (XLEN - shamt));  // Amount 0 leaves b unchanged
            end

            default: begin
                y        = '0;
                overflow = 1'b0;
            end
        endcase
    end

endmodule

/* div_unit.sv */
`timescale 1ns/100ps

module div_unit import exu_pkg::*; (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            start,
    input  logic            signed_op,
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    output logic            done,
    output hilo_t           result
);

    localparam int              CNT_W = $clog2(ITER_COUNT);
    localparam logic [CNT_W-1:0] LAST = CNT_W'(ITER_COUNT - 1);

    logic               run;
    logic               fix;
    logic [CNT_W-1:0]   cnt;
    logic               neg_q;
    logic               neg_r;
    logic [XLEN-1:0]    divisor;
    logic [XLEN-1:0]    rem;
    logic [XLEN-1:0]    quo;      // Dividend bits shift out the top, quotient bits in
    logic [XLEN:0]      part;
    logic [XLEN:0]      diff;
    logic               fits;
    logic [XLEN-1:0]    mag_a;
    logic [XLEN-1:0]    mag_b;

    assign mag_a = (signed_op && a[XLEN-1]) ? -a : a;
    assign mag_b = (signed_op && b[XLEN-1]) ? -b : b;

    assign part = {rem, quo[XLEN-1]};
    assign diff = part - {1'b0, divisor};
    assign fits = (part >= {1'b0, divisor});  // Always true for a zero divisor

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            run  <= 1'b0;
            fix  <= 1'b0;
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            done <= fix;
            fix  <= run && (cnt == LAST);
            if (start) begin
                run <= 1'b1;
                cnt <= '0;
            end else if (run) begin
                cnt <= cnt + 1'b1;
                if (cnt == LAST) begin
                    run <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            rem     <= '0;
            quo     <= mag_a;
            divisor <= mag_b;
            neg_q   <= signed_op && (a[XLEN-1] ^ b[XLEN-1]);
            neg_r   <= signed_op && a[XLEN-1];
        end else if (run) begin
            rem <= fits ? diff[XLEN-1:0] : part[XLEN-1:0];
            quo <= {quo[XLEN-2:0], fits};
        end else if (fix) begin
            // Quotient follows a^b, remainder follows the dividend
            if (neg_q) begin
                quo <= -quo;
            end
            if (neg_r) begin
                rem <= -rem;
            end
        end
    end

    assign result.hi = rem;
    assign result.lo = quo;

    a_div_no_restart: assert property (@(posedge clk) disable iff (!arst_n)
        start |-> !(run || fix));

endmodule

/* exu_ctrl.sv */
`timescale 1ns/100ps

module exu_ctrl import exu_pkg::*; (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            req_valid,
    input  exu_req_t        req,
    output logic            busy,
    output logic            rsp_valid,
    output exu_rsp_t        rsp,
    output alu_op_e         alu_op,
    output logic [XLEN-1:0] alu_a,
    output logic [XLEN-1:0] alu_b,
    input  logic [XLEN-1:0] alu_y,
    input  logic            alu_overflow,
    output logic            mul_start,
    output logic            div_start,
    output logic            md_signed,
    output logic [XLEN-1:0] md_a,
    output logic [XLEN-1:0] md_b,
    input  logic            mul_done,
    input  logic            div_done,
    input  hilo_t           mul_result,
    input  hilo_t           div_result,
    output hilo_t           hilo
);

    ctrl_state_e state;
    exu_req_t    req_q;
    logic        pend;        // req_q holds a request not yet dispatched
    logic        is_mul;
    logic        is_div;
    exu_rsp_t    rsp_d;

    always_ff @(posedge clk) begin
        if (req_valid) begin
            req_q <= req;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pend <= 1'b0;
        end else begin
            pend <= req_valid;
        end
    end

    assign is_mul = req_q.op inside {MULT, MULTU};
    assign is_div = req_q.op inside {DIV, DIVU};

    // ALU and mul/div units all work on the registered request
    assign alu_op    = req_q.op;
    assign alu_a     = req_q.a;
    assign alu_b     = req_q.b;
    assign md_a      = req_q.a;
    assign md_b      = req_q.b;
    assign md_signed = req_q.op inside {MULT, DIV};

    assign mul_start = pend && (state == IDLE) && is_mul;
    assign div_start = pend && (state == IDLE) && is_div;

    assign busy = (state == MUL_RUN) || (state == DIV_RUN);

    always_comb begin
        case (req_q.op)
            MFHI:    rsp_d = '{y: hilo.hi, overflow: 1'b0};
            MFLO:    rsp_d = '{y: hilo.lo, overflow: 1'b0};
            MTHI,
            MTLO,
            MULT,
            MULTU,
            DIV,
            DIVU:    rsp_d = '{y: '0, overflow: 1'b0};
            default: rsp_d = '{y: alu_y, overflow: alu_overflow};
        endcase
    end

    always_ff @(posedge clk) begin
        rsp <= rsp_d;           // Qualified by rsp_valid only
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= IDLE;
            rsp_valid <= 1'b0;
            hilo      <= '0;
        end else begin
            rsp_valid <= 1'b0;
            case (state)
                IDLE: begin
                    if (pend) begin
                        if (is_mul) begin
                            state <= MUL_RUN;
                        end else if (is_div) begin
                            state <= DIV_RUN;
                        end else begin
                            rsp_valid <= 1'b1;
                            if (req_q.op == MTHI) begin
                                hilo.hi <= req_q.a;
                            end
                            if (req_q.op == MTLO) begin
                                hilo.lo <= req_q.a;
                            end
                        end
                    end
                end
                MUL_RUN: begin
                    if (mul_done) begin
                        hilo      <= mul_result;
                        rsp_valid <= 1'b1;
                        state     <= FINISH;
                    end
                end
                DIV_RUN: begin
                    if (div_done) begin
                        hilo      <= div_result;   // hi = remainder, lo = quotient
                        rsp_valid <= 1'b1;
                        state     <= FINISH;
                    end
                end
                FINISH: state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    a_no_req_when_busy: assert property (@(posedge clk) disable iff (!arst_n)
        req_valid |-> !busy);

    a_mul_done_in_run: assert property (@(posedge clk) disable iff (!arst_n)
        mul_done |-> state == MUL_RUN);

    a_div_done_in_run: assert property (@(posedge clk) disable iff (!arst_n)
        div_done |-> state == DIV_RUN);

endmodule

/* exu_pkg.sv */
package exu_pkg;

    localparam int XLEN       = 32;
    localparam int SHAMT_W    = $clog2(XLEN);   // Shift amount taken from a
    localparam int ITER_COUNT = XLEN;           // One bit per cycle for mul and div

    typedef enum logic [7:0] {
        // Arithmetic
        ADD   = 8'h00,
        ADDU  = 8'h01,
        SUB   = 8'h02,
        SUBU  = 8'h03,
        // Compare
        SLT   = 8'h08,
        SLTU  = 8'h09,
        SLTI  = 8'h0a,
        SLTIU = 8'h0b,
        // Logic
        AND   = 8'h10,
        OR    = 8'h11,
        NOR   = 8'h12,
        XOR   = 8'h13,
        LUI   = 8'h14,
        // Shift and rotate
        SLL   = 8'h20,
        SLLV  = 8'h21,
        SRL   = 8'h22,
        SRLV  = 8'h23,
        SRA   = 8'h24,
        SRAV  = 8'h25,
        ROTR  = 8'h26,
        // Multi-cycle
        MULT  = 8'h30,
        MULTU = 8'h31,
        DIV   = 8'h32,
        DIVU  = 8'h33,
        // HI/LO moves
        MFHI  = 8'h38,
        MFLO  = 8'h39,
        MTHI  = 8'h3a,
        MTLO  = 8'h3b
    } alu_op_e;

    typedef struct packed {
        alu_op_e         op;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
    } exu_req_t;

    typedef struct packed {
        logic [XLEN-1:0] y;
        logic            overflow;
    } exu_rsp_t;

    typedef struct packed {
        logic [XLEN-1:0] hi;
        logic [XLEN-1:0] lo;
    } hilo_t;

    typedef enum logic [1:0] {
        IDLE,
        MUL_RUN,
        DIV_RUN,
        FINISH      // Cycle in which a mul/div response is presented
    } ctrl_state_e;

endpackage

/* exu_tests.txt */
# op     code  a         b         y         ov  hi        lo
# hex fields, '-' marks a field that is not checked
ADD      00    7fffffff  00000001  80000000  1   -         -
ADD      00    80000000  80000000  00000000  1   -         -
ADD      00    00000005  fffffffd  00000002  0   -         -
ADDU     01    7fffffff  00000001  80000000  0   -         -
SUB      02    80000000  00000001  7fffffff  1   -         -
SUB      02    00000003  00000005  fffffffe  0   -         -
SUBU     03    80000000  00000001  7fffffff  0   -         -
SLT      08    ffffffff  00000001  00000001  0   -         -
SLT      08    7fffffff  80000000  00000000  0   -         -
SLTU     09    ffffffff  00000001  00000000  0   -         -
SLTI     0a    80000000  7fffffff  00000001  0   -         -
SLTIU    0b    7fffffff  80000000  00000001  0   -         -
AND      10    f0f0a5a5  ff00ff00  f000a500  0   -         -
OR       11    f0f0a5a5  0f0f0000  ffffa5a5  0   -         -
NOR      12    f0f00000  0000000f  0f0ffff0  0   -         -
XOR      13    12345678  ffff0000  edcb5678  0   -         -
LUI      14    00000000  0000abcd  abcd0000  0   -         -
SLL      20    00000004  00000001  00000010  0   -         -
SLLV     21    0000001f  00000003  80000000  0   -         -
SRL      22    00000000  80000000  80000000  0   -         -
SRLV     23    0000003f  80000000  00000001  0   -         -
SRA      24    0000001f  80000000  ffffffff  0   -         -
SRAV     25    00000004  f0000000  ff000000  0   -         -
ROTR     26    00000004  12345678  81234567  0   -         -
ROTR     26    00000000  12345678  12345678  0   -         -
MTHI     3a    13579bdf  00000000  00000000  0   13579bdf  00000000
MTLO     3b    2468ace0  00000000  00000000  0   13579bdf  2468ace0
MFHI     38    00000000  00000000  13579bdf  0   13579bdf  2468ace0
MFLO     39    00000000  00000000  2468ace0  0   13579bdf  2468ace0
MULT     30    fffffffd  00000007  00000000  0   ffffffff  ffffffeb
MFHI     38    00000000  00000000  ffffffff  0   ffffffff  ffffffeb
MFLO     39    00000000  00000000  ffffffeb  0   ffffffff  ffffffeb
MULTU    31    ffffffff  ffffffff  00000000  0   fffffffe  00000001
MULT     30    7fffffff  80000000  00000000  0   c0000000  80000000
DIV      32    fffffff9  00000002  00000000  0   ffffffff  fffffffd
DIV      32    00000007  fffffffe  00000000  0   00000001  fffffffd
DIVU     33    fffffff9  00000002  00000000  0   00000001  7ffffffc
DIVU     33    12345678  00000000  00000000  0   12345678  ffffffff
DIV      32    fffffff0  00000000  00000000  0   fffffff0  00000001
MFHI     38    00000000  00000000  fffffff0  0   fffffff0  00000001
MFLO     39    00000000  00000000  00000001  0   fffffff0  00000001

/* exu_top.sv */
`timescale 1ns/100ps

module exu_top import exu_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     req_valid,
    input  exu_req_t req,
    output logic     busy,
    output logic     rsp_valid,
    output exu_rsp_t rsp,
    output hilo_t    hilo
);

    alu_op_e         alu_op;
    logic [XLEN-1:0] alu_a;
    logic [XLEN-1:0] alu_b;
    logic [XLEN-1:0] alu_y;
    logic            alu_overflow;
    logic            mul_start;
    logic            div_start;
    logic            md_signed;
    logic [XLEN-1:0] md_a;
    logic [XLEN-1:0] md_b;
    logic            mul_done;
    logic            div_done;
    hilo_t           mul_result;
    hilo_t           div_result;

    exu_ctrl i_ctrl (
        .clk          (clk),
        .arst_n       (arst_n),
        .req_valid    (req_valid),
        .req          (req),
        .busy         (busy),
        .rsp_valid    (rsp_valid),
        .rsp          (rsp),
        .alu_op       (alu_op),
        .alu_a        (alu_a),
        .alu_b        (alu_b),
        .alu_y        (alu_y),
        .alu_overflow (alu_overflow),
        .mul_start    (mul_start),
        .div_start    (div_start),
        .md_signed    (md_signed),
        .md_a         (md_a),
        .md_b         (md_b),
        .mul_done     (mul_done),
        .div_done     (div_done),
        .mul_result   (mul_result),
        .div_result   (div_result),
        .hilo         (hilo)
    );

    alu_slave i_alu (
        .op       (alu_op),
        .a        (alu_a),
        .b        (alu_b),
        .y        (alu_y),
        .overflow (alu_overflow)
    );

    mul_unit i_mul (
        .clk       (clk),
        .arst_n    (arst_n),
        .start     (mul_start),
        .signed_op (md_signed),
        .a         (md_a),
        .b         (md_b),
        .done      (mul_done),
        .result    (mul_result)
    );

    div_unit i_div (
        .clk       (clk),
        .arst_n    (arst_n),
        .start     (div_start),
        .signed_op (md_signed),
        .a         (md_a),
        .b         (md_b),
        .done      (div_done),
        .result    (div_result)
    );

endmodule

/* mul_unit.sv */
`timescale 1ns/100ps

module mul_unit import exu_pkg::*; (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            start,
    input  logic            signed_op,
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    output logic            done,
    output hilo_t           result
);

    localparam int              CNT_W = $clog2(ITER_COUNT);
    localparam logic [CNT_W-1:0] LAST = CNT_W'(ITER_COUNT - 1);

    logic               run;
    logic               fix;
    logic [CNT_W-1:0]   cnt;
    logic               neg;
    logic [XLEN-1:0]    mcand;
    logic [2*XLEN-1:0]  prod;     // Upper half accumulates, lower half holds multiplier
    logic [XLEN:0]      sum;
    logic [XLEN-1:0]    mag_a;
    logic [XLEN-1:0]    mag_b;

    assign mag_a = (signed_op && a[XLEN-1]) ? -a : a;
    assign mag_b = (signed_op && b[XLEN-1]) ? -b : b;

    assign sum = {1'b0, prod[2*XLEN-1:XLEN]} + ({(XLEN+1){prod[0]}} & {1'b0, mcand});

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            run  <= 1'b0;
            fix  <= 1'b0;
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            done <= fix;
            fix  <= run && (cnt == LAST);
            if (start) begin
                run <= 1'b1;
                cnt <= '0;
            end else if (run) begin
                cnt <= cnt + 1'b1;
                if (cnt == LAST) begin
                    run <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            mcand <= mag_a;
            prod  <= {{XLEN{1'b0}}, mag_b};
            neg   <= signed_op && (a[XLEN-1] ^ b[XLEN-1]);
        end else if (run) begin
            prod <= {sum, prod[XLEN-1:1]};
        end else if (fix && neg) begin
            prod <= -prod;      // Sign fix of the full 64-bit product
        end
    end

    assign result = prod;

    a_mul_no_restart: assert property (@(posedge clk) disable iff (!arst_n)
        start |-> !(run || fix));

endmodule

/* tb.f */
exu_pkg.sv
alu_slave.sv
mul_unit.sv
div_unit.sv
exu_ctrl.sv
exu_top.sv
tb_exu.sv

/* tb_exu.sv */
`timescale 1ns/100ps

module tb_exu import exu_pkg::*; ();

    localparam int MAX_VEC  = 64;
    localparam int WAIT_MAX = 100;   // Cycles before a wait gives up
    localparam int MD_LAT   = 35;    // req_valid to rsp_valid for mul/div

    typedef struct packed {
        alu_op_e         op;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] y;
        logic            ov;
        logic [XLEN-1:0] hi;
        logic [XLEN-1:0] lo;
        logic            chk_y;
        logic            chk_ov;
        logic            chk_hi;
        logic            chk_lo;
    } test_vec_t;

    logic      clk;
    logic      arst_n;
    logic      req_valid;
    exu_req_t  req;
    logic      busy;
    logic      rsp_valid;
    exu_rsp_t  rsp;
    hilo_t     hilo;

    test_vec_t vecs [MAX_VEC];
    int        num_vecs;
    int        cur_idx;      // Vector index that goes with req_valid
    int        cyc;
    int        pend_idx [$];
    int        pend_cyc [$];
    int        checks;
    int        errors;
    bit        timed_out;
    bit        check_en;
    logic [31:0] rng;

    exu_top i_dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .req_valid (req_valid),
        .req       (req),
        .busy      (busy),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .hilo      (hilo)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic bit is_mul_div(input alu_op_e op);
        return op inside {MULT, MULTU, DIV, DIVU};
    endfunction

    function automatic bit uses_hilo(input alu_op_e op);
        return op inside {MULT, MULTU, DIV, DIVU, MFHI, MFLO, MTHI, MTLO};
    endfunction

    // Returns 0 for a dash
    function automatic bit parse_field(input logic [8*16-1:0] tok, output logic [XLEN-1:0] val);
        int n;
        val = '0;
        n = 0;
        if (tok != "-") begin
            n = $sscanf(tok, "%h", val);
        end
        return n == 1;
    endfunction

    task automatic read_vectors();
        int               fd;
        int               cnt;
        logic [8*128-1:0] line;
        logic [8*8-1:0]   name;
        logic [7:0]       code;
        logic [XLEN-1:0]  a;
        logic [XLEN-1:0]  b;
        logic [8*16-1:0]  t_y;
        logic [8*16-1:0]  t_ov;
        logic [8*16-1:0]  t_hi;
        logic [8*16-1:0]  t_lo;
        logic [XLEN-1:0]  ov;
        test_vec_t        v;
        num_vecs = 0;
        fd = $fopen("exu_tests.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open the vector file exu_tests.txt");
        end else begin
            while (!$feof(fd) && num_vecs < MAX_VEC) begin
                line = '0;
                cnt = $fgets(line, fd);
                cnt = $sscanf(line, "%s %h %h %h %s %s %s %s",
                              name, code, a, b, t_y, t_ov, t_hi, t_lo);
                if (cnt == 8) begin   // Comment and blank lines fall through
                    v.op     = alu_op_e'(code);
                    v.a      = a;
                    v.b      = b;
                    v.chk_y  = parse_field(t_y, v.y);
                    v.chk_ov = parse_field(t_ov, ov);
                    v.ov     = ov[0];
                    v.chk_hi = parse_field(t_hi, v.hi);
                    v.chk_lo = parse_field(t_lo, v.lo);
                    vecs[num_vecs] = v;
                    num_vecs++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic report_value(input string sig, input int idx,
                                input logic [XLEN-1:0] exp, input logic [XLEN-1:0] act);
        errors++;
        $display("FAIL t=%0t %0s vector %0d expected %h actual %h", $time, sig, idx, exp, act);
    endtask

    // Driven on the falling edge, sampled by the DUT at the next rising edge
    task automatic issue(input int idx);
        req_valid = 1'b1;
        req.op    = vecs[idx].op;
        req.a     = vecs[idx].a;
        req.b     = vecs[idx].b;
        cur_idx   = idx;
        @(negedge clk);
        req_valid = 1'b0;
        req       = '0;
    endtask

    task automatic wait_response();
        int n;
        n = 0;
        while (!rsp_valid && n < WAIT_MAX) begin
            @(negedge clk);
            n++;
        end
        if (!rsp_valid) begin
            timed_out = 1'b1;
            $display("Timeout: no response after %0d cycles at t=%0t", WAIT_MAX, $time);
        end
    endtask

    // Outputs are stable at the falling edge
    task automatic check_outputs();
        int        idx;
        int        age;
        int        lat;
        bit        busy_exp;
        test_vec_t v;
        busy_exp = 1'b0;
        idx      = -1;
        if (pend_idx.size() == 0) begin
            checks++;
            assert (rsp_valid === 1'b0) else begin
                errors++;
                $display("Response at t=%0t with no request outstanding", $time);
            end
        end else begin
            idx      = pend_idx[0];
            v        = vecs[idx];
            age      = cyc - pend_cyc[0];
            lat      = is_mul_div(v.op) ? MD_LAT : 1;
            busy_exp = is_mul_div(v.op) && age >= 1 && age < lat;
            checks++;
            if (age < lat) begin
                assert (rsp_valid === 1'b0) else begin
                    errors++;
                    $display("Response to vector %0d came early at t=%0t", idx, $time);
                end
            end else begin
                assert (rsp_valid === 1'b1) else report_value("rsp_valid", idx, 1, rsp_valid);
                if (rsp_valid === 1'b1) begin
                    if (v.chk_y) begin
                        checks++;
                        assert (rsp.y === v.y) else report_value("rsp.y", idx, v.y, rsp.y);
                    end
                    if (v.chk_ov) begin
                        checks++;
                        assert (rsp.overflow === v.ov)
                            else report_value("rsp.overflow", idx, v.ov, rsp.overflow);
                    end
                    if (v.chk_hi) begin
                        checks++;
                        assert (hilo.hi === v.hi) else report_value("hilo.hi", idx, v.hi, hilo.hi);
                    end
                    if (v.chk_lo) begin
                        checks++;
                        assert (hilo.lo === v.lo) else report_value("hilo.lo", idx, v.lo, hilo.lo);
                    end
                end
                void'(pend_idx.pop_front());
                void'(pend_cyc.pop_front());
            end
        end
        checks++;
        assert (busy === busy_exp) else report_value("busy", idx, busy_exp, busy);
    endtask

    always @(posedge clk) begin
        cyc = cyc + 1;
        if (arst_n && req_valid) begin
            pend_idx.push_back(cur_idx);
            pend_cyc.push_back(cyc);
        end
    end

    always @(negedge clk) begin
        if (check_en) begin
            check_outputs();
        end
    end

    initial begin
        int n;
        arst_n    = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        cur_idx   = 0;
        cyc       = 0;
        checks    = 0;
        errors    = 0;
        timed_out = 1'b0;
        check_en  = 1'b0;
        rng       = 32'h47ab;
        read_vectors();
        if (num_vecs == 0) begin
            errors++;
            $display("No test vectors were read");
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        @(posedge clk);
        check_en = 1'b1;
        @(negedge clk);

        // All vectors in file order with random gaps
        for (int i = 0; i < num_vecs && !timed_out; i++) begin
            rng = xorshift(rng);
            repeat (rng[1:0]) @(negedge clk);
            issue(i);
            if (is_mul_div(vecs[i].op)) begin
                wait_response();
            end
        end

        // Pure ALU vectors again, back to back
        for (int i = 0; i < num_vecs && !timed_out; i++) begin
            if (!uses_hilo(vecs[i].op)) begin
                issue(i);
            end
        end

        @(posedge clk);
        n = 0;
        while (!timed_out && pend_idx.size() > 0 && n < WAIT_MAX) begin
            @(posedge clk);
            n++;
        end
        if (pend_idx.size() > 0) begin
            timed_out = 1'b1;
            $display("Timeout: %0d responses still outstanding", pend_idx.size());
        end

        $display("Checks: %0d, errors: %0d, timeout: %0d", checks, errors, timed_out);
        if (errors == 0 && !timed_out && checks > 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
